// File: verilog/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

`define MBOX_DEPTH      16

// Mailbox word addresses
`define SLOT_SPI_TXD    0
`define SLOT_SPI_CTRL   1
`define SLOT_SPI_STAT   2
`define SLOT_SPI_RXD    3
`define SLOT_UART_TXD   4
`define SLOT_UART_CTRL  5
`define SLOT_UART_STAT  6
`define SLOT_UART_RXD   7

`define CTRL_GO         0
`define SPI_DIV_HI      15      // Half-period of sck in clocks
`define SPI_DIV_LO      8
`define SPI_SEL_HI      17
`define SPI_SEL_LO      16
`define UART_DIV_HI     31      // Bit period in clocks
`define UART_DIV_LO     16

`define STAT_BUSY       0
`define STAT_CNT_HI     15
`define STAT_CNT_LO     8
`define STAT_RXCNT_HI   23      // UART only
`define STAT_RXCNT_LO   16

`endif

// File: verilog/periph_pkg.sv
`include "periph_config.svh"

package periph_pkg;

	typedef logic [31:0] word_t;
	typedef logic [$clog2(`MBOX_DEPTH)-1:0] mbox_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] div_t;

	// One state per sweep step
	typedef enum logic [3:0] {
		S_SPI_TXD,
		S_SPI_CTRL,
		S_SPI_LAUNCH,
		S_SPI_STAT,
		S_SPI_RXD,
		S_UART_TXD,
		S_UART_CTRL,
		S_UART_LAUNCH,
		S_UART_STAT,
		S_UART_RXD
	} seq_state_t;

endpackage

// File: verilog/mailbox_ram.sv
`include "periph_config.svh"

module mailbox_ram (
	input  logic                   clk,

	input  periph_pkg::mbox_addr_t i_host_addr,
	input  periph_pkg::word_t      i_host_wdata,
	input  logic                   i_host_we,
	output periph_pkg::word_t      o_host_rdata,

	input  periph_pkg::mbox_addr_t i_seq_addr,
	input  periph_pkg::word_t      i_seq_wdata,
	input  logic                   i_seq_we,
	output periph_pkg::word_t      o_seq_rdata
);
	import periph_pkg::*;

	word_t mem [`MBOX_DEPTH];
	logic  seq_wr_ok;

	assign seq_wr_ok = i_seq_we & ~(i_host_we & (i_host_addr == i_seq_addr));   // Host wins

	always_ff @(posedge clk) begin
		if (i_host_we) begin
			mem[i_host_addr] <= i_host_wdata;
		end
		if (seq_wr_ok) begin
			mem[i_seq_addr] <= i_seq_wdata;
		end
		o_host_rdata <= mem[i_host_addr];   // Old data on a same-cycle write
		o_seq_rdata  <= mem[i_seq_addr];
	end

endmodule

// File: verilog/mbox_sequencer.sv
`include "periph_config.svh"

module mbox_sequencer (
	input  logic                   clk,
	input  logic                   nrst,

	output periph_pkg::mbox_addr_t o_mem_addr,
	output periph_pkg::word_t      o_mem_wdata,
	output logic                   o_mem_we,
	input  periph_pkg::word_t      i_mem_rdata,

	output logic                   o_spi_start,
	output periph_pkg::byte_t      o_spi_txd,
	output logic [1:0]             o_spi_sel,
	output periph_pkg::div_t       o_spi_div,
	input  logic                   i_spi_busy,
	input  periph_pkg::byte_t      i_spi_rxd,
	input  periph_pkg::byte_t      i_spi_count,

	output logic                   o_tx_start,
	output periph_pkg::byte_t      o_tx_byte,
	output periph_pkg::div_t       o_uart_div,
	input  logic                   i_tx_busy,
	input  periph_pkg::byte_t      i_tx_count,
	input  periph_pkg::byte_t      i_rx_byte,
	input  periph_pkg::byte_t      i_rx_count
);
	import periph_pkg::*;

	seq_state_t state;
	seq_state_t state_next;
	word_t      spi_stat;
	word_t      uart_stat;
	word_t      ctrl_done;
	logic       spi_launch;
	logic       uart_launch;

	assign ctrl_done = i_mem_rdata & ~(word_t'(1) << `CTRL_GO);

	// A pending start counts as busy so STAT never shows a gap
	always_comb begin
		spi_stat = '0;
		spi_stat[`STAT_BUSY] = i_spi_busy | o_spi_start;
		spi_stat[`STAT_CNT_HI:`STAT_CNT_LO] = i_spi_count;
		uart_stat = '0;
		uart_stat[`STAT_BUSY] = i_tx_busy | o_tx_start;
		uart_stat[`STAT_CNT_HI:`STAT_CNT_LO] = i_tx_count;
		uart_stat[`STAT_RXCNT_HI:`STAT_RXCNT_LO] = i_rx_count;
	end

	always_comb begin
		o_mem_addr  = '0;
		o_mem_wdata = '0;
		o_mem_we    = 1'b0;
		spi_launch  = 1'b0;
		uart_launch = 1'b0;
		state_next  = S_SPI_TXD;
		case (state)
			S_SPI_TXD: begin
				o_mem_addr = mbox_addr_t'(`SLOT_SPI_TXD);
				state_next = S_SPI_CTRL;
			end
			S_SPI_CTRL: begin
				o_mem_addr = mbox_addr_t'(`SLOT_SPI_CTRL);   // TXD word arrives now
				state_next = S_SPI_LAUNCH;
			end
			S_SPI_LAUNCH: begin
				spi_launch  = i_mem_rdata[`CTRL_GO] & ~i_spi_busy;
				o_mem_addr  = mbox_addr_t'(`SLOT_SPI_CTRL);
				o_mem_wdata = ctrl_done;
				o_mem_we    = spi_launch;
				state_next  = S_SPI_STAT;
			end
			S_SPI_STAT: begin
				o_mem_addr  = mbox_addr_t'(`SLOT_SPI_STAT);
				o_mem_wdata = spi_stat;
				o_mem_we    = 1'b1;
				state_next  = S_SPI_RXD;
			end
			S_SPI_RXD: begin
				o_mem_addr  = mbox_addr_t'(`SLOT_SPI_RXD);
				o_mem_wdata = word_t'(i_spi_rxd);
				o_mem_we    = 1'b1;
				state_next  = S_UART_TXD;
			end
			S_UART_TXD: begin
				o_mem_addr = mbox_addr_t'(`SLOT_UART_TXD);
				state_next = S_UART_CTRL;
			end
			S_UART_CTRL: begin
				o_mem_addr = mbox_addr_t'(`SLOT_UART_CTRL);
				state_next = S_UART_LAUNCH;
			end
			S_UART_LAUNCH: begin
				uart_launch = i_mem_rdata[`CTRL_GO] & ~i_tx_busy;
				o_mem_addr  = mbox_addr_t'(`SLOT_UART_CTRL);
				o_mem_wdata = ctrl_done;
				o_mem_we    = uart_launch;
				state_next  = S_UART_STAT;
			end
			S_UART_STAT: begin
				o_mem_addr  = mbox_addr_t'(`SLOT_UART_STAT);
				o_mem_wdata = uart_stat;
				o_mem_we    = 1'b1;
				state_next  = S_UART_RXD;
			end
			S_UART_RXD: begin
				o_mem_addr  = mbox_addr_t'(`SLOT_UART_RXD);
				o_mem_wdata = word_t'(i_rx_byte);
				o_mem_we    = 1'b1;
				state_next  = S_SPI_TXD;
			end
			default: begin
				state_next = S_SPI_TXD;
			end
		endcase
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state       <= S_SPI_TXD;
			o_spi_start <= 1'b0;
			o_tx_start  <= 1'b0;
			o_spi_sel   <= '0;
			o_spi_div   <= '0;
			o_uart_div  <= '0;
		end else begin
			state       <= state_next;
			o_spi_start <= spi_launch;
			o_tx_start  <= uart_launch;
			if (spi_launch) begin
				o_spi_sel <= i_mem_rdata[`SPI_SEL_HI:`SPI_SEL_LO];
				o_spi_div <= div_t'(i_mem_rdata[`SPI_DIV_HI:`SPI_DIV_LO]);
			end
			if (uart_launch) begin
				o_uart_div <= i_mem_rdata[`UART_DIV_HI:`UART_DIV_LO];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_SPI_CTRL) begin
			o_spi_txd <= i_mem_rdata[7:0];
		end
		if (state == S_UART_CTRL) begin
			o_tx_byte <= i_mem_rdata[7:0];
		end
	end

	a_we_states: assert property (@(posedge clk) disable iff (!nrst)
		o_mem_we |-> state inside {S_SPI_LAUNCH, S_SPI_STAT, S_SPI_RXD,
			S_UART_LAUNCH, S_UART_STAT, S_UART_RXD});

	// Engines must take every start that the sequencer issues
	a_spi_accept: assert property (@(posedge clk) disable iff (!nrst)
		o_spi_start |=> i_spi_busy);
	a_tx_accept: assert property (@(posedge clk) disable iff (!nrst)
		o_tx_start |=> i_tx_busy);

endmodule

// File: verilog/bit_timer.sv
module bit_timer (
	input  logic             clk,
	input  logic             nrst,
	input  logic             i_spi_run,
	input  periph_pkg::div_t i_spi_div,
	output logic             o_spi_tick,
	input  logic             i_tx_run,
	input  periph_pkg::div_t i_tx_div,
	output logic             o_tx_tick,
	input  logic             i_rx_run,
	input  periph_pkg::div_t i_rx_div,
	output logic             o_rx_tick
);
	import periph_pkg::*;

	localparam logic [2:0] HALF_FIRST = 3'b100;   // Receive channel starts at mid-bit

	logic [2:0] run;
	div_t       div [3];

	assign run = {i_rx_run, i_tx_run, i_spi_run};
	assign div = '{i_spi_div, i_tx_div, i_rx_div};

	// Divisors below 2, or 4 on the receive channel, are not supported
	for (genvar g = 0; g < 3; g++) begin : g_chan
		div_t cnt;
		div_t first_lim;
		logic first;
		logic tick;

		assign first_lim = HALF_FIRST[g] ? (div[g] >> 1) : div[g];
		assign tick = run[g] & ~first & (cnt == '0);

		always_ff @(posedge clk or negedge nrst) begin
			if (!nrst) begin
				cnt   <= '0;
				first <= 1'b1;
			end else if (!run[g]) begin
				cnt   <= '0;
				first <= 1'b1;
			end else if (first) begin
				cnt   <= first_lim - div_t'(2);   // The run-rise cycle already counts
				first <= 1'b0;
			end else if (cnt == '0) begin
				cnt <= div[g] - div_t'(1);
			end else begin
				cnt <= cnt - div_t'(1);
			end
		end

		a_tick_single: assert property (@(posedge clk) disable iff (!nrst)
			tick |=> !tick);
	end

	assign o_spi_tick = g_chan[0].tick;
	assign o_tx_tick  = g_chan[1].tick;
	assign o_rx_tick  = g_chan[2].tick;

endmodule

// File: verilog/spi_master.sv
module spi_master (
	input  logic              clk,
	input  logic              nrst,
	input  logic              i_start,
	input  periph_pkg::byte_t i_txd,
	input  logic [1:0]        i_sel,
	output logic              o_busy,
	output logic              o_run,
	input  logic              i_tick,
	output periph_pkg::byte_t o_rxd,
	output periph_pkg::byte_t o_count,
	output logic              o_sck,
	output logic              o_mosi,
	input  logic              i_miso,
	output logic [3:0]        o_ss
);
	import periph_pkg::*;

	byte_t      shift;
	logic [3:0] edge_cnt;   // Half-periods done
	logic       miso_bit;
	logic       last_edge;

	assign o_run     = o_busy;
	assign o_mosi    = shift[7];   // MSB first
	assign last_edge = (edge_cnt == 4'd15);

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			o_busy   <= 1'b0;
			o_sck    <= 1'b0;
			o_ss     <= 4'hf;
			edge_cnt <= '0;
			o_count  <= '0;
		end else if (!o_busy) begin
			if (i_start) begin
				o_busy   <= 1'b1;
				o_ss     <= ~(4'b0001 << i_sel);
				edge_cnt <= '0;
			end
		end else if (i_tick) begin
			o_sck    <= ~o_sck;
			edge_cnt <= edge_cnt + 4'd1;
			if (last_edge) begin
				o_busy  <= 1'b0;
				o_ss    <= 4'hf;
				o_count <= o_count + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!o_busy && i_start) begin
			shift <= i_txd;
		end else if (o_busy && i_tick) begin
			if (!o_sck) begin
				miso_bit <= i_miso;   // Rising sck
			end else begin
				shift <= {shift[6:0], miso_bit};
			end
			if (last_edge) begin
				o_rxd <= {shift[6:0], miso_bit};
			end
		end
	end

	a_ss_idle: assert property (@(posedge clk) disable iff (!nrst)
		!o_busy |-> (o_ss == 4'hf));

endmodule

// File: verilog/uart_tx.sv
module uart_tx (
	input  logic              clk,
	input  logic              nrst,
	input  logic              i_start,
	input  periph_pkg::byte_t i_byte,
	output logic              o_busy,
	output logic              o_run,
	input  logic              i_tick,
	output periph_pkg::byte_t o_count,
	output logic              o_txd
);
	logic [8:0] shift;     // Stop bit above the data
	logic [3:0] bit_cnt;

	assign o_run = o_busy;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			o_busy  <= 1'b0;
			o_txd   <= 1'b1;
			bit_cnt <= '0;
			o_count <= '0;
		end else if (!o_busy) begin
			if (i_start) begin
				o_busy  <= 1'b1;
				o_txd   <= 1'b0;   // Start bit
				bit_cnt <= '0;
			end
		end else if (i_tick) begin
			if (bit_cnt == 4'd9) begin
				o_busy  <= 1'b0;
				o_count <= o_count + 8'd1;
			end else begin
				o_txd   <= shift[0];
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!o_busy && i_start) begin
			shift <= {1'b1, i_byte};
		end else if (o_busy && i_tick) begin
			shift <= {1'b1, shift[8:1]};
		end
	end

endmodule

// File: verilog/uart_rx.sv
module uart_rx (
	input  logic              clk,
	input  logic              nrst,
	input  logic              i_rxd,
	output logic              o_run,
	input  logic              i_tick,
	output periph_pkg::byte_t o_byte,
	output periph_pkg::byte_t o_count
);
	import periph_pkg::*;

	logic       rxd_meta;
	logic       rxd_sync;
	logic       rxd_prev;
	logic       active;
	logic [3:0] bit_cnt;   // 0 start, 1-8 data, 9 stop
	byte_t      shift;

	assign o_run = active;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
			active   <= 1'b0;
			bit_cnt  <= '0;
			o_count  <= '0;
		end else begin
			rxd_meta <= i_rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
			if (!active) begin
				if (rxd_prev && !rxd_sync) begin
					active  <= 1'b1;
					bit_cnt <= '0;
				end
			end else if (i_tick) begin
				if (bit_cnt == 4'd0) begin
					if (rxd_sync) begin
						active <= 1'b0;   // Glitch, not a start bit
					end else begin
						bit_cnt <= 4'd1;
					end
				end else if (bit_cnt == 4'd9) begin
					active <= 1'b0;
					if (rxd_sync) begin
						o_count <= o_count + 8'd1;
					end
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active && i_tick) begin
			if (bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
				shift <= {rxd_sync, shift[7:1]};   // LSB first
			end
			if (bit_cnt == 4'd9 && rxd_sync) begin
				o_byte <= shift;
			end
		end
	end

endmodule

// File: verilog/periph_hub.sv
module periph_hub (
	input  logic                   clk,
	input  logic                   nrst,
	input  periph_pkg::mbox_addr_t i_host_addr,
	input  periph_pkg::word_t      i_host_wdata,
	input  logic                   i_host_we,
	output periph_pkg::word_t      o_host_rdata,
	output logic                   o_sck,
	output logic                   o_mosi,
	input  logic                   i_miso,
	output logic [3:0]             o_ss,
	output logic                   o_uart_txd,
	input  logic                   i_uart_rxd
);
	import periph_pkg::*;

	mbox_addr_t seq_addr;
	word_t      seq_wdata;
	word_t      seq_rdata;
	logic       seq_we;

	logic       spi_start;
	logic       spi_busy;
	logic       spi_run;
	logic       spi_tick;
	logic [1:0] spi_sel;
	byte_t      spi_txd;
	byte_t      spi_rxd;
	byte_t      spi_count;
	div_t       spi_div;

	logic       tx_start;
	logic       tx_busy;
	logic       tx_run;
	logic       tx_tick;
	byte_t      tx_byte;
	byte_t      tx_count;
	div_t       uart_div;

	logic       rx_run;
	logic       rx_tick;
	byte_t      rx_byte;
	byte_t      rx_count;

	mailbox_ram mailbox_ram_inst (
		.clk(clk),
		.i_host_addr(i_host_addr), .i_host_wdata(i_host_wdata),
		.i_host_we(i_host_we), .o_host_rdata(o_host_rdata),
		.i_seq_addr(seq_addr), .i_seq_wdata(seq_wdata),
		.i_seq_we(seq_we), .o_seq_rdata(seq_rdata)
	);

	mbox_sequencer mbox_sequencer_inst (
		.clk(clk), .nrst(nrst),
		.o_mem_addr(seq_addr), .o_mem_wdata(seq_wdata),
		.o_mem_we(seq_we), .i_mem_rdata(seq_rdata),
		.o_spi_start(spi_start), .o_spi_txd(spi_txd), .o_spi_sel(spi_sel),
		.o_spi_div(spi_div), .i_spi_busy(spi_busy), .i_spi_rxd(spi_rxd),
		.i_spi_count(spi_count),
		.o_tx_start(tx_start), .o_tx_byte(tx_byte), .o_uart_div(uart_div),
		.i_tx_busy(tx_busy), .i_tx_count(tx_count),
		.i_rx_byte(rx_byte), .i_rx_count(rx_count)
	);

	bit_timer bit_timer_inst (
		.clk(clk), .nrst(nrst),
		.i_spi_run(spi_run), .i_spi_div(spi_div), .o_spi_tick(spi_tick),
		.i_tx_run(tx_run), .i_tx_div(uart_div), .o_tx_tick(tx_tick),
		.i_rx_run(rx_run), .i_rx_div(uart_div), .o_rx_tick(rx_tick)
	);

	spi_master spi_master_inst (
		.clk(clk), .nrst(nrst),
		.i_start(spi_start), .i_txd(spi_txd), .i_sel(spi_sel),
		.o_busy(spi_busy), .o_run(spi_run), .i_tick(spi_tick),
		.o_rxd(spi_rxd), .o_count(spi_count),
		.o_sck(o_sck), .o_mosi(o_mosi), .i_miso(i_miso), .o_ss(o_ss)
	);

	uart_tx uart_tx_inst (
		.clk(clk), .nrst(nrst),
		.i_start(tx_start), .i_byte(tx_byte),
		.o_busy(tx_busy), .o_run(tx_run), .i_tick(tx_tick),
		.o_count(tx_count), .o_txd(o_uart_txd)
	);

	uart_rx uart_rx_inst (
		.clk(clk), .nrst(nrst),
		.i_rxd(i_uart_rxd), .o_run(rx_run), .i_tick(rx_tick),
		.o_byte(rx_byte), .o_count(rx_count)
	);

endmodule

// File: tb/tb_periph_hub.sv
`include "periph_config.svh"

module tb_periph_hub;
	import periph_pkg::*;

	localparam int         POLL_LIMIT     = 200;   // Mailbox reads before giving up
	localparam word_t      GO_MASK        = word_t'(1) << `CTRL_GO;
	localparam word_t      SPI_STAT_MASK  = 32'h0000_ff01;   // Busy and done count
	localparam word_t      UART_STAT_MASK = 32'h00ff_ff01;
	localparam mbox_addr_t SPI_TXD        = mbox_addr_t'(`SLOT_SPI_TXD);
	localparam mbox_addr_t SPI_CTRL       = mbox_addr_t'(`SLOT_SPI_CTRL);
	localparam mbox_addr_t SPI_STAT       = mbox_addr_t'(`SLOT_SPI_STAT);
	localparam mbox_addr_t SPI_RXD        = mbox_addr_t'(`SLOT_SPI_RXD);
	localparam mbox_addr_t UART_TXD       = mbox_addr_t'(`SLOT_UART_TXD);
	localparam mbox_addr_t UART_CTRL      = mbox_addr_t'(`SLOT_UART_CTRL);
	localparam mbox_addr_t UART_STAT      = mbox_addr_t'(`SLOT_UART_STAT);
	localparam mbox_addr_t UART_RXD       = mbox_addr_t'(`SLOT_UART_RXD);

	logic        clk;
	logic        nrst;
	mbox_addr_t  host_addr;
	word_t       host_wdata;
	logic        host_we;
	word_t       host_rdata;
	logic        sck;
	logic        mosi;
	logic [3:0]  ss;
	logic        uart_line;

	logic [15:0] lfsr;
	logic [3:0]  exp_ss;   // Select pattern of the transfer in flight
	byte_t       spi_cnt;
	byte_t       tx_cnt;
	byte_t       rx_cnt;
	int          ss_low_cycles = 0;
	int          ss_errors = 0;
	int          sck_errors = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_errors_at;
	string       test_name;

	periph_hub periph_hub_inst (
		.clk(clk),
		.nrst(nrst),
		.i_host_addr(host_addr),
		.i_host_wdata(host_wdata),
		.i_host_we(host_we),
		.o_host_rdata(host_rdata),
		.o_sck(sck),
		.o_mosi(mosi),
		.i_miso(mosi),   // SPI loopback
		.o_ss(ss),
		.o_uart_txd(uart_line),
		.i_uart_rxd(uart_line)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (nrst && ss != 4'hf) begin
			ss_low_cycles <= ss_low_cycles + 1;
		end
	end

	a_ss_select: assert property (@(posedge clk) disable iff (!nrst)
		(ss != 4'hf) |-> (ss == exp_ss))
		else begin
			ss_errors++;
			$display("ERR t=%0t o_ss got %b expected %b", $time, ss, exp_ss);
		end

	// Mode 0 keeps sck low between transfers
	a_sck_idle: assert property (@(posedge clk) disable iff (!nrst)
		(ss == 4'hf) |-> !sck)
		else begin
			sck_errors++;
			$display("ERR t=%0t o_sck got %b expected 0", $time, sck);
		end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
	endfunction

	function automatic int error_total();
		return errors + ss_errors + sck_errors;
	endfunction

	task automatic random_byte(output byte_t b);
		int i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic mbox_write(input mbox_addr_t addr, input word_t data);
		@(negedge clk);
		host_addr  = addr;
		host_wdata = data;
		host_we    = 1'b1;
		@(negedge clk);
		host_we = 1'b0;
	endtask

	task automatic mbox_read(input mbox_addr_t addr, output word_t data);
		@(negedge clk);
		host_addr = addr;
		host_we   = 1'b0;
		@(negedge clk);
		data = host_rdata;   // One cycle read latency
	endtask

	task automatic poll_slot(input mbox_addr_t addr, input word_t mask, input word_t exp,
			output word_t data);
		int n;
		n = 0;
		mbox_read(addr, data);
		while (((data & mask) != exp) && n < POLL_LIMIT) begin
			mbox_read(addr, data);
			n++;
		end
		if ((data & mask) != exp) begin
			errors++;
			$display("Timeout at t=%0t: mailbox slot %0d never reached %h within %0d reads",
				$time, addr, exp, POLL_LIMIT);
		end
	endtask

	task automatic expect_word(input string name, input word_t got, input word_t exp);
		checks++;
		a_value: assert (got === exp) else begin
			errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic begin_test(input string name);
		test_name      = name;
		test_errors_at = error_total();
	endtask

	task automatic end_test();
		tests++;
		if (error_total() == test_errors_at) begin
			$display("test %0d %s: ok", tests, test_name);
		end else begin
			$display("test %0d %s: %0d error(s)", tests, test_name,
				error_total() - test_errors_at);
		end
	endtask

	task automatic run_spi(input logic [1:0] sel, input byte_t div, input byte_t data);
		word_t ctrl;
		word_t stat;
		word_t rd;
		int    low0;

		ctrl        = (word_t'(sel) << `SPI_SEL_LO) | (word_t'(div) << `SPI_DIV_LO) | GO_MASK;
		exp_ss      = 4'hf;
		exp_ss[sel] = 1'b0;   // Only the selected slave goes low
		low0        = ss_low_cycles;
		mbox_write(SPI_TXD, word_t'(data));
		mbox_write(SPI_CTRL, ctrl);
		poll_slot(SPI_CTRL, GO_MASK, '0, rd);
		expect_word("spi ctrl", rd, ctrl & ~GO_MASK);
		spi_cnt = spi_cnt + 8'd1;
		stat    = word_t'(spi_cnt) << `STAT_CNT_LO;
		poll_slot(SPI_STAT, SPI_STAT_MASK, stat, rd);
		expect_word("spi stat", rd, stat);
		mbox_read(SPI_RXD, rd);
		expect_word("spi rxd", rd, word_t'(data));
		expect_word("o_ss low cycles", word_t'(ss_low_cycles - low0), word_t'(16 * div));
	endtask

	initial begin
		int    i;
		byte_t b1;
		byte_t b2;
		word_t ctrl;
		word_t stat;
		word_t rd;
		int    low0;

		nrst       = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		host_we    = 1'b0;
		lfsr       = 16'd13;
		exp_ss     = 4'hf;
		spi_cnt    = '0;
		tx_cnt     = '0;
		rx_cnt     = '0;

		// Request slots start clear and result slots hold a marker while the hub is held
		for (i = 0; i < 8; i++) begin
			if (i % 4 < 2) begin
				mbox_write(mbox_addr_t'(i), '0);
			end else begin
				mbox_write(mbox_addr_t'(i), {8{mbox_addr_t'(i)}});
			end
		end
		nrst = 1'b1;

		begin_test("reset state");
		expect_word("o_ss", word_t'(ss), 32'h0000_000f);
		expect_word("o_sck", word_t'(sck), '0);
		expect_word("o_uart_txd", word_t'(uart_line), 32'h0000_0001);
		poll_slot(SPI_STAT, '1, '0, rd);
		expect_word("spi stat", rd, '0);
		poll_slot(UART_STAT, '1, '0, rd);
		expect_word("uart stat", rd, '0);
		end_test();

		begin_test("spi loopback sel 2");
		random_byte(b1);
		run_spi(2'd2, 8'd4, b1);
		end_test();

		begin_test("spi ctrl go clear");
		random_byte(b1);
		run_spi(2'd1, 8'd3, b1);
		end_test();

		begin_test("uart loopback div 8");
		random_byte(b1);
		ctrl = (word_t'(16'd8) << `UART_DIV_LO) | GO_MASK;
		mbox_write(UART_TXD, word_t'(b1));
		mbox_write(UART_CTRL, ctrl);
		poll_slot(UART_CTRL, GO_MASK, '0, rd);
		expect_word("uart ctrl", rd, ctrl & ~GO_MASK);
		tx_cnt = tx_cnt + 8'd1;
		rx_cnt = rx_cnt + 8'd1;
		stat   = (word_t'(rx_cnt) << `STAT_RXCNT_LO) | (word_t'(tx_cnt) << `STAT_CNT_LO);
		poll_slot(UART_STAT, UART_STAT_MASK, stat, rd);
		expect_word("uart stat", rd, stat);
		mbox_read(UART_RXD, rd);
		expect_word("uart rxd", rd, word_t'(b1));
		expect_word("o_uart_txd", word_t'(uart_line), 32'h0000_0001);
		end_test();

		begin_test("spi back-to-back");
		random_byte(b1);
		random_byte(b2);
		ctrl   = (word_t'(8'd4) << `SPI_DIV_LO) | GO_MASK;   // Select 0
		exp_ss = 4'b1110;
		low0   = ss_low_cycles;
		mbox_write(SPI_TXD, word_t'(b1));
		mbox_write(SPI_CTRL, ctrl);
		poll_slot(SPI_CTRL, GO_MASK, '0, rd);
		mbox_write(SPI_TXD, word_t'(b2));
		mbox_write(SPI_CTRL, ctrl);   // Lands while the first byte shifts
		mbox_read(SPI_STAT, rd);
		expect_word("spi stat", rd, (word_t'(spi_cnt) << `STAT_CNT_LO) | 32'h1);
		spi_cnt = spi_cnt + 8'd2;
		stat    = word_t'(spi_cnt) << `STAT_CNT_LO;
		poll_slot(SPI_STAT, SPI_STAT_MASK, stat, rd);
		expect_word("spi stat", rd, stat);
		mbox_read(SPI_RXD, rd);
		expect_word("spi rxd", rd, word_t'(b2));
		mbox_read(SPI_CTRL, rd);
		expect_word("spi ctrl", rd, ctrl & ~GO_MASK);
		expect_word("o_ss low cycles", word_t'(ss_low_cycles - low0), 32'd128);
		end_test();

		begin_test("status slot rewrite");
		mbox_write(SPI_STAT, 32'hdead_beef);
		stat = word_t'(spi_cnt) << `STAT_CNT_LO;
		poll_slot(SPI_STAT, '1, stat, rd);
		expect_word("spi stat", rd, stat);
		mbox_write(UART_STAT, 32'h5a5a_a5a5);
		stat = (word_t'(rx_cnt) << `STAT_RXCNT_LO) | (word_t'(tx_cnt) << `STAT_CNT_LO);
		poll_slot(UART_STAT, '1, stat, rd);
		expect_word("uart stat", rd, stat);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, error_total());
		if (error_total() == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+verilog
verilog/periph_pkg.sv
verilog/mailbox_ram.sv
verilog/mbox_sequencer.sv
verilog/bit_timer.sv
verilog/spi_master.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/periph_hub.sv
tb/tb_periph_hub.sv

// File: Makefile
TOP = tb_periph_hub

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module $(TOP) -f compile.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

clean:
	rm -rf obj_dir sim.log
